// File: fetch_consts.svh
`ifndef FETCH_CONSTS_SVH
`define FETCH_CONSTS_SVH

// address and instruction width
`define FETCH_XLEN 32

// byte offset bits inside one word
`define FETCH_OFS_W 2

// cache index bits for 16 lines
`define FETCH_IDX_W 4

// remaining upper address bits form the tag
`define FETCH_TAG_W (`FETCH_XLEN - `FETCH_IDX_W - `FETCH_OFS_W)

// number of cache lines
`define FETCH_LINES (1 << `FETCH_IDX_W)

// read response code for a good beat
`define FETCH_RESP_OKAY 2'b00

`endif

// File: fetch_pkg.sv
`default_nettype none

`include "fetch_consts.svh"

package fetch_pkg;

    // one fetch address seen as a plain word or split for the cache
    typedef union packed {
        logic [`FETCH_XLEN-1:0] raw;
        struct packed {
            logic [`FETCH_TAG_W-1:0] tag;
            logic [`FETCH_IDX_W-1:0] index;
            logic [`FETCH_OFS_W-1:0] offset;
        } f;
    } fetch_addr_u;

    // fetch control states
    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        LOOKUP = 2'b01,
        CHECK  = 2'b10,
        BUSY   = 2'b11
    } fetch_state_e;

endpackage

`default_nettype wire

// File: fetch_icache.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_icache (
    input  wire                    clk,
    input  wire                    rst,

    // lookup request from the fetch unit
    input  wire                    icache_req,
    input  wire [`FETCH_XLEN-1:0]  lookup_addr,

    // refill from the read channel
    input  wire                    fill_valid,
    input  wire [`FETCH_XLEN-1:0]  fill_data,

    input  wire                    icache_flush,

    output logic                   icache_hit,
    output logic [`FETCH_XLEN-1:0] icache_data,
    output logic                   mem_req
);

    localparam int LINES = `FETCH_LINES;

    fetch_pkg::fetch_addr_u look;
    fetch_pkg::fetch_addr_u req_addr;

    logic [LINES-1:0]         line_valid;
    logic [`FETCH_TAG_W-1:0]  tag_mem  [LINES];
    logic [`FETCH_XLEN-1:0]   data_mem [LINES];
    logic                     look_hit;

    ////////////////////////////////////////////////////////////
    // lookup
    ////////////////////////////////////////////////////////////

    assign look = lookup_addr;

    assign look_hit = line_valid[look.f.index] &&
                      (tag_mem[look.f.index] == look.f.tag);

    ////////////////////////////////////////////////////////////
    // valid bits and lookup result
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            line_valid <= '0;
            icache_hit <= 1'b0;
            mem_req    <= 1'b0;
        end else begin
            if (icache_req) begin
                icache_hit <= look_hit;
                mem_req    <= !look_hit;
            end else if (fill_valid) begin
                mem_req <= 1'b0;
            end

            if (fill_valid) begin
                line_valid[req_addr.f.index] <= 1'b1;
            end

            // flush wins over a fill in the same cycle
            if (icache_flush) begin
                line_valid <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // tag and data arrays
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (icache_req) begin
            req_addr    <= look;
            icache_data <= data_mem[look.f.index];
        end

        // fill goes to the line of the address that missed
        if (fill_valid) begin
            tag_mem[req_addr.f.index]  <= req_addr.f.tag;
            data_mem[req_addr.f.index] <= fill_data;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // a refill only answers an outstanding miss
    fill_during_miss: assert property (
        @(posedge clk) disable iff (rst)
        fill_valid |-> mem_req
    );

    // the fetch unit never looks up while a fill lands
    req_fill_excl: assert property (
        @(posedge clk) disable iff (rst)
        !(icache_req && fill_valid)
    );

endmodule

`default_nettype wire

// File: fetch_ifu.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_ifu (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [`FETCH_XLEN-1:0]  pc,

    // decode side
    input  wire                    idu_ready,
    output logic                   inst_valid,
    output logic [`FETCH_XLEN-1:0] inst,
    output logic                   fetch_err,

    // cache side
    input  wire                    icache_hit,
    input  wire [`FETCH_XLEN-1:0]  icache_data,
    input  wire                    mem_req,
    output logic                   icache_req,
    output logic [`FETCH_XLEN-1:0] lookup_addr,
    output logic                   fill_valid,

    // AXI-lite read channels
    output logic [`FETCH_XLEN-1:0] araddr,
    output logic                   arvalid,
    input  wire                    arready,
    input  wire [`FETCH_XLEN-1:0]  rdata,
    input  wire [1:0]              rresp,
    input  wire                    rvalid,
    output logic                   rready
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::fetch_addr_u  last_pc;

    logic beat;
    logic beat_ok;

    assign beat    = rvalid && rready;
    assign beat_ok = beat && (rresp == `FETCH_RESP_OKAY);

    // only a good beat refills the cache
    assign fill_valid  = beat_ok;
    assign lookup_addr = last_pc.raw;

    ////////////////////////////////////////////////////////////
    // fetch state machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= fetch_pkg::IDLE;
            last_pc.raw <= '1;
            icache_req  <= 1'b0;
            arvalid     <= 1'b0;
            rready      <= 1'b0;
            inst_valid  <= 1'b0;
            fetch_err   <= 1'b0;
        end else begin
            icache_req <= 1'b0;
            case (state)
                fetch_pkg::IDLE: begin
                    if (pc != last_pc.raw) begin
                        last_pc.raw <= pc;
                        icache_req  <= 1'b1;
                        state       <= fetch_pkg::LOOKUP;
                    end
                end
                fetch_pkg::LOOKUP: begin
                    // the cache answers one edge after the request
                    if (!icache_req) begin
                        state <= fetch_pkg::CHECK;
                    end
                end
                fetch_pkg::CHECK: begin
                    if (inst_valid) begin
                        if (idu_ready) begin
                            inst_valid <= 1'b0;
                            state      <= fetch_pkg::IDLE;
                        end
                    end else if (icache_hit) begin
                        inst_valid <= 1'b1;
                    end else if (mem_req) begin
                        arvalid <= 1'b1;
                        state   <= fetch_pkg::BUSY;
                    end
                end
                fetch_pkg::BUSY: begin
                    if (inst_valid) begin
                        if (idu_ready) begin
                            inst_valid <= 1'b0;
                            fetch_err  <= 1'b0;
                            state      <= fetch_pkg::IDLE;
                        end
                    end else begin
                        if (arvalid && arready) begin
                            arvalid <= 1'b0;
                            rready  <= 1'b1;
                        end
                        if (beat) begin
                            rready     <= 1'b0;
                            inst_valid <= 1'b1;
                            fetch_err  <= !beat_ok;
                        end
                    end
                end
                default: state <= fetch_pkg::IDLE;
            endcase
        end
    end

    // output word and read address
    always_ff @(posedge clk) begin
        if (state == fetch_pkg::CHECK && !inst_valid) begin
            if (icache_hit) begin
                inst <= icache_data;
            end else begin
                araddr <= last_pc.raw;
            end
        end
        if (state == fetch_pkg::BUSY && beat) begin
            inst <= beat_ok ? rdata : '0;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    ar_hold: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid
    );

    ar_addr_stable: assert property (
        @(posedge clk) disable iff (rst)
        arvalid && !arready |=> $stable(araddr)
    );

    no_valid_in_idle: assert property (
        @(posedge clk) disable iff (rst)
        state == fetch_pkg::IDLE |-> !inst_valid
    );

endmodule

`default_nettype wire

// File: fetch_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module fetch_top (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [`FETCH_XLEN-1:0]  pc,
    input  wire                    idu_ready,
    input  wire                    icache_flush,
    input  wire                    arready,
    input  wire [`FETCH_XLEN-1:0]  rdata,
    input  wire [1:0]              rresp,
    input  wire                    rvalid,
    output wire                    inst_valid,
    output wire [`FETCH_XLEN-1:0]  inst,
    output wire                    fetch_err,
    output wire [`FETCH_XLEN-1:0]  araddr,
    output wire                    arvalid,
    output wire                    rready
);

    wire                   icache_req;
    wire [`FETCH_XLEN-1:0] lookup_addr;
    wire                   fill_valid;
    wire                   icache_hit;
    wire [`FETCH_XLEN-1:0] icache_data;
    wire                   mem_req;

    fetch_ifu u_ifu (
        .clk         (clk),
        .rst         (rst),
        .pc          (pc),
        .idu_ready   (idu_ready),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .fetch_err   (fetch_err),
        .icache_hit  (icache_hit),
        .icache_data (icache_data),
        .mem_req     (mem_req),
        .icache_req  (icache_req),
        .lookup_addr (lookup_addr),
        .fill_valid  (fill_valid),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rdata       (rdata),
        .rresp       (rresp),
        .rvalid      (rvalid),
        .rready      (rready)
    );

    // refill data comes straight off the read channel
    fetch_icache u_icache (
        .clk          (clk),
        .rst          (rst),
        .icache_req   (icache_req),
        .lookup_addr  (lookup_addr),
        .fill_valid   (fill_valid),
        .fill_data    (rdata),
        .icache_flush (icache_flush),
        .icache_hit   (icache_hit),
        .icache_data  (icache_data),
        .mem_req      (mem_req)
    );

endmodule

`default_nettype wire

// File: tb_clk_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for the first 10 cycles
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: tb_axi_mem.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module tb_axi_mem #(
    parameter logic [`FETCH_XLEN-1:0] ERR_BASE = 32'h8000_0000
) (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [`FETCH_XLEN-1:0]  araddr,
    input  wire                    arvalid,
    output logic                   arready,
    output logic [`FETCH_XLEN-1:0] rdata,
    output logic [1:0]             rresp,
    output logic                   rvalid,
    input  wire                    rready,
    output logic [31:0]            ar_count,
    output logic [`FETCH_XLEN-1:0] ar_last
);

    localparam logic [1:0] RESP_SLVERR = 2'b10;

    integer                  seed = 32'h248c_d3d3;
    int                      wait_cnt;
    logic                    r_phase;
    logic [`FETCH_XLEN-1:0]  req_addr;

    // extra wait of 0 to 5 cycles
    function automatic int pick_delay();
        return $unsigned($random(seed)) % 6;
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            arready  <= 1'b0;
            rvalid   <= 1'b0;
            rdata    <= '0;
            rresp    <= '0;
            r_phase  <= 1'b0;
            wait_cnt <= pick_delay();
            ar_count <= '0;
            ar_last  <= '0;
            req_addr <= '0;
        end else if (!r_phase) begin
            if (arvalid && arready) begin
                arready  <= 1'b0;
                ar_count <= ar_count + 1;
                ar_last  <= araddr;
                req_addr <= araddr;
                wait_cnt <= pick_delay();
                r_phase  <= 1'b1;
            end else if (arvalid) begin
                if (wait_cnt == 0) begin
                    arready <= 1'b1;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end else begin
            if (rvalid && rready) begin
                rvalid   <= 1'b0;
                r_phase  <= 1'b0;
                wait_cnt <= pick_delay();
            end else if (!rvalid) begin
                if (wait_cnt == 0) begin
                    rvalid <= 1'b1;
                    // data is the inverted address even in the error region
                    rdata  <= ~req_addr;
                    rresp  <= (req_addr >= ERR_BASE) ? RESP_SLVERR : `FETCH_RESP_OKAY;
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb_fetch.sv
`timescale 1ns/100ps
`default_nettype none

`include "fetch_consts.svh"

module tb_fetch;

    localparam int TIMEOUT = 100;
    localparam int HIT_LAT = 3;

    localparam logic [`FETCH_XLEN-1:0] ERR_BASE = 32'h8000_0000;
    localparam logic [`FETCH_XLEN-1:0] ADDR_A   = 32'h0000_0100;
    localparam logic [`FETCH_XLEN-1:0] ADDR_B   = 32'h0000_0204;
    // same index as A with another tag
    localparam logic [`FETCH_XLEN-1:0] ADDR_C   = 32'h0000_1100;
    localparam logic [`FETCH_XLEN-1:0] ADDR_H1  = 32'h0000_0308;
    localparam logic [`FETCH_XLEN-1:0] ADDR_H2  = 32'h0000_0410;
    localparam logic [`FETCH_XLEN-1:0] ADDR_E   = 32'h8000_0010;

    wire                   clk;
    wire                   rst;
    logic [`FETCH_XLEN-1:0] pc;
    logic                  idu_ready;
    logic                  icache_flush;
    wire                   inst_valid;
    wire [`FETCH_XLEN-1:0] inst;
    wire                   fetch_err;
    wire [`FETCH_XLEN-1:0] araddr;
    wire                   arvalid;
    wire                   arready;
    wire [`FETCH_XLEN-1:0] rdata;
    wire [1:0]             rresp;
    wire                   rvalid;
    wire                   rready;
    wire [31:0]            ar_count;
    wire [`FETCH_XLEN-1:0] ar_last;

    int test_errs;
    int tests_passed;
    int tests_failed;
    bit timed_out;

    tb_clk_gen u_clk (
        .clk (clk),
        .rst (rst)
    );

    tb_axi_mem #(
        .ERR_BASE (ERR_BASE)
    ) u_mem (
        .clk      (clk),
        .rst      (rst),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .ar_count (ar_count),
        .ar_last  (ar_last)
    );

    fetch_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .pc           (pc),
        .idu_ready    (idu_ready),
        .icache_flush (icache_flush),
        .arready      (arready),
        .rdata        (rdata),
        .rresp        (rresp),
        .rvalid       (rvalid),
        .inst_valid   (inst_valid),
        .inst         (inst),
        .fetch_err    (fetch_err),
        .araddr       (araddr),
        .arvalid      (arvalid),
        .rready       (rready)
    );

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic compare(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
        if (expected !== actual) begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            test_errs++;
        end
    endtask

    // counts rising edges after the pc drive until inst_valid shows up
    task automatic wait_inst_valid(input string name, output int edges);
        edges = 0;
        forever begin
            @(posedge clk);
            edges++;
            @(negedge clk);
            if (inst_valid) break;
            if (edges >= TIMEOUT) begin
                $display("%s: no instruction came back within %0d cycles, fetch FSM in %s",
                         name, TIMEOUT, u_dut.u_ifu.state.name());
                timed_out = 1'b1;
                test_errs++;
                break;
            end
        end
    endtask

    task automatic fetch_word(input string name, input logic [31:0] addr, input int hold,
                              output logic [31:0] word, output logic err, output int lat);
        int edges;
        int i;
        @(posedge clk);
        pc <= addr;
        if (hold > 0) begin
            idu_ready <= 1'b0;
        end
        wait_inst_valid(name, edges);
        // the first edge after the drive is where the fetch unit samples pc
        lat  = edges - 1;
        word = inst;
        err  = fetch_err;
        if (timed_out) return;
        // the word has to stay put while decode stalls
        for (i = 0; i < hold; i++) begin
            @(negedge clk);
            compare(name, 1, inst_valid);
            compare(name, word, inst);
        end
        if (hold > 0) begin
            @(posedge clk);
            idu_ready <= 1'b1;
        end
        @(posedge clk);
        @(negedge clk);
        compare(name, 0, inst_valid);
    endtask

    task automatic report_result(input string name);
        if (test_errs == 0) begin
            tests_passed++;
            $display("%s: passed", name);
        end else begin
            tests_failed++;
            $display("%s: failed with %0d errors", name, test_errs);
        end
        test_errs = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////

    task automatic reset_values();
        int n;
        n = 0;
        @(negedge clk);
        while (rst && n < TIMEOUT) begin
            compare("reset", 0, {inst_valid, fetch_err, arvalid, rready});
            @(negedge clk);
            n++;
        end
        if (rst) begin
            $display("reset: reset never went low within %0d cycles", TIMEOUT);
            timed_out = 1'b1;
            test_errs++;
            return;
        end
        repeat (4) begin
            compare("reset", 0, {inst_valid, fetch_err, arvalid, rready});
            @(negedge clk);
        end
    endtask

    task automatic cold_miss();
        logic [31:0] word;
        logic        err;
        int          lat;
        logic [31:0] ar0;
        ar0 = ar_count;
        fetch_word("cold_miss", ADDR_A, 6, word, err, lat);
        if (timed_out) return;
        compare("cold_miss", ~ADDR_A, word);
        compare("cold_miss", 0, err);
        compare("cold_miss", ar0 + 1, ar_count);
        compare("cold_miss", ADDR_A, ar_last);
    endtask

    task automatic hit_path();
        logic [31:0] w1;
        logic [31:0] word;
        logic        err;
        int          lat;
        logic [31:0] ar0;
        fetch_word("hit_path", ADDR_H1, 0, w1, err, lat);
        fetch_word("hit_path", ADDR_H2, 0, word, err, lat);
        if (timed_out) return;
        ar0 = ar_count;
        fetch_word("hit_path", ADDR_H1, 0, word, err, lat);
        if (timed_out) return;
        compare("hit_path", ~ADDR_H1, w1);
        compare("hit_path", ~ADDR_H1, word);
        compare("hit_path", ar0, ar_count);
        compare("hit_path", HIT_LAT, lat);
    endtask

    task automatic tag_conflict();
        logic [31:0] word;
        logic        err;
        int          lat;
        logic [31:0] ar0;
        fetch_word("tag_conflict", ADDR_A, 0, word, err, lat);
        ar0 = ar_count;
        fetch_word("tag_conflict", ADDR_C, 0, word, err, lat);
        if (timed_out) return;
        compare("tag_conflict", ~ADDR_C, word);
        compare("tag_conflict", ar0 + 1, ar_count);
        // C evicted A from the shared line
        ar0 = ar_count;
        fetch_word("tag_conflict", ADDR_A, 0, word, err, lat);
        if (timed_out) return;
        compare("tag_conflict", ~ADDR_A, word);
        compare("tag_conflict", ar0 + 1, ar_count);
    endtask

    task automatic error_response();
        logic [31:0] word;
        logic        err;
        int          lat;
        logic [31:0] ar0;
        ar0 = ar_count;
        fetch_word("error_response", ADDR_E, 0, word, err, lat);
        if (timed_out) return;
        compare("error_response", 1, err);
        compare("error_response", 0, word);
        compare("error_response", ar0 + 1, ar_count);
        fetch_word("error_response", ADDR_B, 0, word, err, lat);
        ar0 = ar_count;
        fetch_word("error_response", ADDR_E, 0, word, err, lat);
        if (timed_out) return;
        compare("error_response", 1, err);
        compare("error_response", 0, word);
        compare("error_response", ar0 + 1, ar_count);
    endtask

    task automatic flush_refetch();
        logic [31:0] word;
        logic        err;
        int          lat;
        logic [31:0] ar0;
        ar0 = ar_count;
        fetch_word("flush_refetch", ADDR_A, 0, word, err, lat);
        if (timed_out) return;
        compare("flush_refetch", ar0, ar_count);
        @(posedge clk);
        icache_flush <= 1'b1;
        @(posedge clk);
        icache_flush <= 1'b0;
        @(negedge clk);
        fetch_word("flush_refetch", ADDR_B, 0, word, err, lat);
        ar0 = ar_count;
        fetch_word("flush_refetch", ADDR_A, 0, word, err, lat);
        if (timed_out) return;
        compare("flush_refetch", ar0 + 1, ar_count);
        compare("flush_refetch", ~ADDR_A, word);
        compare("flush_refetch", 0, err);
    endtask

    ////////////////////////////////////////////////////////////
    // sequence
    ////////////////////////////////////////////////////////////

    initial begin
        // all ones matches the reset value of the last fetched pc
        pc           = '1;
        idu_ready    = 1'b1;
        icache_flush = 1'b0;
        test_errs    = 0;
        tests_passed = 0;
        tests_failed = 0;
        timed_out    = 1'b0;

        reset_values();
        report_result("reset");
        if (!timed_out) begin
            cold_miss();
            report_result("cold_miss");
        end
        if (!timed_out) begin
            hit_path();
            report_result("hit_path");
        end
        if (!timed_out) begin
            tag_conflict();
            report_result("tag_conflict");
        end
        if (!timed_out) begin
            error_response();
            report_result("error_response");
        end
        if (!timed_out) begin
            flush_refetch();
            report_result("flush_refetch");
        end

        $display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (timed_out || tests_failed != 0) begin
            $display("Test FAILED");
        end else begin
            $display("Test OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
fetch_pkg.sv
fetch_icache.sv
fetch_ifu.sv
fetch_top.sv
tb_clk_gen.sv
tb_axi_mem.sv
tb_fetch.sv

// File: Bender.yml
package:
  name: fetch

sources:
  - include_dirs:
      - .
    files:
      - fetch_pkg.sv
      - fetch_icache.sv
      - fetch_ifu.sv
      - fetch_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_clk_gen.sv
      - tb_axi_mem.sv
      - tb_fetch.sv
